//--- source/pq_pkg.sv
`default_nettype none

package pq_pkg;

    // packet word width on ingress, egress and inside the fifos
    localparam int data_w = 32;

    // packet length field width in the header
    localparam int len_w = 8;

    // apb address width, enough for the four word registers
    localparam int addr_w = 4;

    // width of the drop and forward counters
    localparam int cnt_w = 16;

    // apb byte offsets
    localparam logic [addr_w-1:0] reg_ctrl     = 4'h0;
    localparam logic [addr_w-1:0] reg_status   = 4'h4;
    localparam logic [addr_w-1:0] reg_drop_cnt = 4'h8;
    localparam logic [addr_w-1:0] reg_fwd_cnt  = 4'hc;

    // header layout of the first word of every packet
    // prio sits in the top bits, 0 is the lowest priority
    typedef struct packed {
        // target priority queue
        logic [2:0]       prio;
        // packet length in words, header word included
        logic [len_w-1:0] len;
        // flow tag, carried through untouched
        logic [20:0]      tag;
    } pkt_hdr_t;

    // one packet word, read as header on sop or as raw payload
    typedef union packed {
        pkt_hdr_t          hdr;
        logic [data_w-1:0] raw;
    } pkt_word_u;

endpackage

`default_nettype wire

//--- source/pkt_word_if.sv
`default_nettype none

// framed word link between a fifo and its neighbours
interface pkt_word_if import pq_pkg::*; ();

    logic              sop;
    logic              eop;
    logic              vld;
    logic [data_w-1:0] data;
    // head advance request, only used on the read link
    logic              next;

    // classifier side of a write link
    modport wr (output sop, eop, vld, data);

    // fifo side of a write link
    modport fifo_wr (input sop, eop, vld, data);

    // scheduler side of a read link
    modport rd (input sop, eop, vld, data, output next);

    // fifo side of a read link
    modport fifo_rd (output sop, eop, vld, data, input next);

endinterface

`default_nettype wire

//--- source/pkt_fifo.sv
`default_nettype none

module pkt_fifo import pq_pkg::*; #(
    parameter int fifo_depth = 32
) (
    input  wire                            clk,
    input  wire                            rst,
    pkt_word_if.fifo_wr                    wr,
    pkt_word_if.fifo_rd                    rd,
    output logic [$clog2(fifo_depth):0]    free_words,
    output logic                           pkt_avail
);

    localparam int aw = $clog2(fifo_depth);

    // stored word is {sop, eop, vld, data}
    logic [data_w+2:0] mem [fifo_depth];

    // pointers one bit wider than the address
    logic [aw:0] wptr;
    logic [aw:0] rptr;
    logic [aw:0] used;

    // complete packets held, each packet is at least one word
    logic [aw:0] pkt_cnt;

    logic full;
    logic empty;
    logic head_vld;
    logic wr_eop;
    logic rd_eop;

    assign used  = wptr - rptr;
    assign full  = (used == (aw+1)'(fifo_depth));
    assign empty = (wptr == rptr);

    assign free_words = (aw+1)'(fifo_depth) - used;

    // head word goes straight out to the scheduler
    assign {rd.sop, rd.eop, head_vld, rd.data} = mem[rptr[aw-1:0]];
    assign rd.vld = head_vld && !empty;

    // packet boundaries crossing the buffer
    assign wr_eop = wr.vld && wr.eop;
    assign rd_eop = rd.next && rd.eop;

    // high from the cycle after an eop write
    assign pkt_avail = (pkt_cnt != '0);

    // storage, written on every valid word
    always_ff @(posedge clk) begin
        if (wr.vld) begin
            mem[wptr[aw-1:0]] <= {wr.sop, wr.eop, wr.vld, wr.data};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (wr.vld) begin
                wptr <= wptr + 1'b1;
            end
            // head moves only on a scheduler request
            if (rd.next) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    // complete packet count
    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_cnt <= '0;
        end else begin
            case ({wr_eop, rd_eop})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    // classifier reserves room at sop so a write never meets a full buffer
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst) wr.vld |-> !full
    );

    // scheduler reads only inside a complete packet
    a_no_early_read : assert property (
        @(posedge clk) disable iff (rst) rd.next |-> pkt_avail
    );

endmodule

`default_nettype wire

//--- source/pkt_classifier.sv
`default_nettype none

module pkt_classifier import pq_pkg::*; #(
    parameter int num_prio = 4
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_sop,
    input  wire                 in_eop,
    input  wire                 in_vld,
    input  wire  [data_w-1:0]   in_data,
    input  wire  [num_prio-1:0] prio_en,
    input  wire  [len_w-1:0]    free_words [num_prio],
    pkt_word_if.wr              q [num_prio],
    output logic                drop
);

    // incoming word seen through the header layout
    pkt_word_u word;

    logic keep_now;
    logic keep_cur;
    logic [2:0] sel_cur;

    // per-packet state, latched on sop
    logic             in_pkt;
    logic             keep_q;
    logic [2:0]       sel_q;
    logic [len_w-1:0] len_q;
    logic [len_w-1:0] word_cnt;

    assign word.raw = in_data;

    // keep test on the header word
    // prio at or above num_prio never matches a queue
    always_comb begin
        keep_now = 1'b0;
        for (int i = 0; i < num_prio; i++) begin
            if (word.hdr.prio == 3'(i)) begin
                keep_now = prio_en[i] && (free_words[i] >= word.hdr.len);
            end
        end
    end

    // sop decides this very cycle, later words follow the latched choice
    // stray words outside a packet are never kept
    assign keep_cur = in_sop ? keep_now : (in_pkt && keep_q);
    assign sel_cur  = in_sop ? word.hdr.prio : sel_q;

    // steer to one write link, payload fans out to all of them
    for (genvar g = 0; g < num_prio; g++) begin : g_steer
        assign q[g].sop  = in_sop;
        assign q[g].eop  = in_eop;
        assign q[g].data = in_data;
        assign q[g].vld  = in_vld && keep_cur && (sel_cur == 3'(g));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt   <= 1'b0;
            keep_q   <= 1'b0;
            sel_q    <= '0;
            len_q    <= '0;
            word_cnt <= '0;
            drop     <= 1'b0;
        end else begin
            // one pulse per dropped packet
            drop <= in_vld && in_sop && !keep_now;
            if (in_vld) begin
                if (in_sop) begin
                    keep_q   <= keep_now;
                    sel_q    <= word.hdr.prio;
                    len_q    <= word.hdr.len;
                    word_cnt <= len_w'(1);
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
                // single word packets never open
                in_pkt <= in_sop ? !in_eop : (in_pkt && !in_eop);
            end
        end
    end

    // no new packet before the current eop
    a_sop_inside : assert property (
        @(posedge clk) disable iff (rst) (in_vld && in_sop) |-> !in_pkt
    );

    // eop within the header length
    a_len_bound : assert property (
        @(posedge clk) disable iff (rst)
        (in_vld && !in_sop && in_pkt) |-> (word_cnt < len_q)
    );

endmodule

`default_nettype wire

//--- source/strict_sched.sv
`default_nettype none

module strict_sched import pq_pkg::*; #(
    parameter int num_prio = 4
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire  [num_prio-1:0] pkt_avail,
    pkt_word_if.rd              q [num_prio],
    input  wire                 out_ready,
    output logic                out_sop,
    output logic                out_eop,
    output logic                out_vld,
    output logic [data_w-1:0]   out_data,
    output logic                fwd
);

    localparam int sel_w = $clog2(num_prio);

    // head words of all queues, flattened for indexed access
    logic [num_prio-1:0] head_sop;
    logic [num_prio-1:0] head_eop;
    logic [num_prio-1:0] head_vld;
    logic [data_w-1:0]   head_data [num_prio];

    logic             busy;
    logic [sel_w-1:0] grant;
    logic [sel_w-1:0] hi_idx;
    logic             take;

    // highest set flag wins
    always_comb begin
        hi_idx = '0;
        for (int i = 0; i < num_prio; i++) begin
            if (pkt_avail[i]) begin
                hi_idx = sel_w'(i);
            end
        end
    end

    for (genvar g = 0; g < num_prio; g++) begin : g_head
        assign head_sop[g]  = q[g].sop;
        assign head_eop[g]  = q[g].eop;
        assign head_vld[g]  = q[g].vld;
        assign head_data[g] = q[g].data;
        // advance only the granted queue, only on a transfer
        assign q[g].next = take && (grant == sel_w'(g));
    end

    // granted head held on egress until accepted
    assign out_vld  = busy && head_vld[grant];
    assign out_sop  = head_sop[grant];
    assign out_eop  = head_eop[grant];
    assign out_data = head_data[grant];

    assign take = out_vld && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            grant <= '0;
            fwd   <= 1'b0;
        end else begin
            fwd <= take && out_eop;
            if (!busy) begin
                // lock on the first edge with any packet waiting
                if (|pkt_avail) begin
                    busy  <= 1'b1;
                    grant <= hi_idx;
                end
            end else if (take && out_eop) begin
                busy <= 1'b0;
            end
        end
    end

    // the granted fifo head must start a packet
    a_grant_sop : assert property (
        @(posedge clk) disable iff (rst) $rose(busy) |-> (out_vld && out_sop)
    );

endmodule

`default_nettype wire

//--- source/pq_regs.sv
`default_nettype none

module pq_regs import pq_pkg::*; #(
    parameter int num_prio = 4
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire  [addr_w-1:0]   paddr,
    input  wire  [data_w-1:0]   pwdata,
    output logic [data_w-1:0]   prdata,
    output logic                pready,
    output logic                pslverr,
    input  wire                 drop,
    input  wire                 fwd,
    input  wire  [num_prio-1:0] pkt_avail,
    output logic [num_prio-1:0] prio_en
);

    logic [cnt_w-1:0] drop_cnt;
    logic [cnt_w-1:0] fwd_cnt;

    logic access;
    logic mapped;
    logic wr_ctrl;
    logic wr_drop;
    logic wr_fwd;

    // access phase of a transfer, no wait states
    assign access = psel && penable;
    assign pready = 1'b1;

    assign mapped = (paddr == reg_ctrl) || (paddr == reg_status) ||
                    (paddr == reg_drop_cnt) || (paddr == reg_fwd_cnt);

    assign pslverr = access && !mapped;

    // write strobes per register
    assign wr_ctrl = access && pwrite && (paddr == reg_ctrl);
    assign wr_drop = access && pwrite && (paddr == reg_drop_cnt);
    assign wr_fwd  = access && pwrite && (paddr == reg_fwd_cnt);

    // read mux
    always_comb begin
        case (paddr)
            reg_ctrl:     prdata = data_w'(prio_en);
            reg_status:   prdata = data_w'(pkt_avail);
            reg_drop_cnt: prdata = data_w'(drop_cnt);
            reg_fwd_cnt:  prdata = data_w'(fwd_cnt);
            default:      prdata = '0;
        endcase
    end

    // enable mask, all priorities on after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            prio_en <= '1;
        end else if (wr_ctrl) begin
            prio_en <= pwdata[num_prio-1:0];
        end
    end

    // counters saturate
    // an event in the clearing cycle still counts
    always_ff @(posedge clk) begin
        if (rst) begin
            drop_cnt <= '0;
        end else if (wr_drop) begin
            drop_cnt <= cnt_w'(drop);
        end else if (drop && (drop_cnt != '1)) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwd_cnt <= '0;
        end else if (wr_fwd) begin
            fwd_cnt <= cnt_w'(fwd);
        end else if (fwd && (fwd_cnt != '1)) begin
            fwd_cnt <= fwd_cnt + 1'b1;
        end
    end

    // access phase follows a setup phase with the same address
    a_apb_phase : assert property (
        @(posedge clk) disable iff (rst)
        access |-> ($past(psel && !penable) && $stable(paddr) && $stable(pwrite))
    );

endmodule

`default_nettype wire

//--- source/pq_top.sv
`default_nettype none

module pq_top import pq_pkg::*; #(
    parameter int num_prio   = 4,
    parameter int fifo_depth = 32
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_sop,
    input  wire                 in_eop,
    input  wire                 in_vld,
    input  wire  [data_w-1:0]   in_data,
    output logic                out_sop,
    output logic                out_eop,
    output logic                out_vld,
    output logic [data_w-1:0]   out_data,
    input  wire                 out_ready,
    input  wire                 psel,
    input  wire                 penable,
    input  wire                 pwrite,
    input  wire  [addr_w-1:0]   paddr,
    input  wire  [data_w-1:0]   pwdata,
    output logic [data_w-1:0]   prdata,
    output logic                pready,
    output logic                pslverr
);

    localparam int fw_w = $clog2(fifo_depth) + 1;

    // classifier to fifo and fifo to scheduler links
    pkt_word_if wr_q [num_prio] ();
    pkt_word_if rd_q [num_prio] ();

    logic [num_prio-1:0] prio_en;
    logic [num_prio-1:0] pkt_avail;
    logic [fw_w-1:0]     fifo_free [num_prio];
    // free space clamped to the header length range
    logic [len_w-1:0]    cls_free [num_prio];
    logic                drop;
    logic                fwd;

    pq_regs #(.num_prio(num_prio)) i_regs (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .drop(drop), .fwd(fwd), .pkt_avail(pkt_avail), .prio_en(prio_en)
    );

    pkt_classifier #(.num_prio(num_prio)) i_cls (
        .clk(clk), .rst(rst),
        .in_sop(in_sop), .in_eop(in_eop), .in_vld(in_vld), .in_data(in_data),
        .prio_en(prio_en), .free_words(cls_free), .q(wr_q), .drop(drop)
    );

    for (genvar g = 0; g < num_prio; g++) begin : g_fifo
        pkt_fifo #(.fifo_depth(fifo_depth)) i_fifo (
            .clk(clk), .rst(rst),
            .wr(wr_q[g]), .rd(rd_q[g]),
            .free_words(fifo_free[g]), .pkt_avail(pkt_avail[g])
        );
        // anything above the longest packet counts as room enough
        assign cls_free[g] = (fifo_free[g] >= fw_w'(2**len_w - 1)) ? '1
                                                                 : len_w'(fifo_free[g]);
    end

    strict_sched #(.num_prio(num_prio)) i_sched (
        .clk(clk), .rst(rst),
        .pkt_avail(pkt_avail), .q(rd_q), .out_ready(out_ready),
        .out_sop(out_sop), .out_eop(out_eop), .out_vld(out_vld),
        .out_data(out_data), .fwd(fwd)
    );

endmodule

`default_nettype wire

//--- tests/pq_clk_gen.sv
`default_nettype none

// free running clock for the testbench
module pq_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // half period of 2 ns, 4 ns period
    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/pq_tb.sv
`default_nettype none

module pq_tb import pq_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_entries  = 23;
    localparam int wait_limit = 2000;

    // one table row per packet
    typedef struct packed {
        logic [2:0]       prio;
        logic [len_w-1:0] len;
        logic [20:0]      tag;
        logic [3:0]       mask;
        // expected to leave on egress
        logic             keep;
        // egress held off while the batch loads
        logic             stall;
        // row closes a batch, egress is drained after it
        logic             last;
        // random out_ready while draining
        logic             rnd;
    } entry_t;

    // columns: prio, len, tag, mask, keep, stall, last, rnd
    localparam entry_t tbl [n_entries] = '{
        '{3'd0, 8'd1,  21'h0a001, 4'hf, 1'b1, 1'b0, 1'b1, 1'b0},
        '{3'd2, 8'd4,  21'h0a002, 4'hf, 1'b1, 1'b0, 1'b1, 1'b0},
        '{3'd3, 8'd6,  21'h0a003, 4'hf, 1'b1, 1'b0, 1'b1, 1'b0},
        '{3'd1, 8'd3,  21'h0a004, 4'hf, 1'b1, 1'b0, 1'b1, 1'b0},
        '{3'd1, 8'd3,  21'h1b001, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd2,  21'h1b002, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd3, 8'd4,  21'h1b003, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd2, 8'd5,  21'h1b004, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd3, 8'd2,  21'h1b005, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd3,  21'h1b006, 4'hf, 1'b1, 1'b1, 1'b1, 1'b0},
        '{3'd2, 8'd7,  21'h2c001, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd2, 8'd5,  21'h2c002, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd8,  21'h2c003, 4'hf, 1'b1, 1'b1, 1'b1, 1'b1},
        '{3'd1, 8'd4,  21'h3d001, 4'hd, 1'b0, 1'b0, 1'b0, 1'b0},
        '{3'd3, 8'd3,  21'h3d002, 4'hd, 1'b1, 1'b0, 1'b0, 1'b0},
        '{3'd1, 8'd2,  21'h3d003, 4'hd, 1'b0, 1'b0, 1'b1, 1'b0},
        '{3'd5, 8'd2,  21'h3d004, 4'hf, 1'b0, 1'b0, 1'b1, 1'b0},
        '{3'd0, 8'd10, 21'h4e001, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd10, 21'h4e002, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd10, 21'h4e003, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd8,  21'h4e004, 4'hf, 1'b0, 1'b1, 1'b0, 1'b0},
        '{3'd0, 8'd2,  21'h4e005, 4'hf, 1'b1, 1'b1, 1'b0, 1'b0},
        '{3'd2, 8'd5,  21'h4e006, 4'hf, 1'b1, 1'b1, 1'b1, 1'b0}
    };

    wire                 clk;
    logic                rst;
    logic                in_sop;
    logic                in_eop;
    logic                in_vld;
    logic [data_w-1:0]   in_data;
    wire                 out_sop;
    wire                 out_eop;
    wire                 out_vld;
    wire  [data_w-1:0]   out_data;
    logic                out_ready;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [addr_w-1:0]   paddr;
    logic [data_w-1:0]   pwdata;
    wire  [data_w-1:0]   prdata;
    wire                 pready;
    wire                 pslverr;

    integer              seed;
    // words sent per table row, header first
    logic [data_w-1:0]   pkt_mem [n_entries][256];
    // egress words as {sop, eop, data}
    logic [data_w+1:0]   rx_q [$];
    int                  fwd_exp;
    int                  drop_exp;
    logic [3:0]          cur_mask;
    logic                hold_pend;
    logic [data_w+1:0]   held_word;

    pq_clk_gen i_clk_gen (.clk(clk));

    pq_top #(.num_prio(4), .fifo_depth(32)) i_dut (
        .clk(clk), .rst(rst),
        .in_sop(in_sop), .in_eop(in_eop), .in_vld(in_vld), .in_data(in_data),
        .out_sop(out_sop), .out_eop(out_eop), .out_vld(out_vld),
        .out_data(out_data), .out_ready(out_ready),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    // setup phase, access phase, done at the access edge
    task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        check_value(pready, 1'b1, "pready on write");
        check_value(pslverr, 1'b0, "pslverr on write");
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [addr_w-1:0] addr, input logic exp_err,
                            output logic [data_w-1:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        check_value(pready, 1'b1, "pready on read");
        check_value(pslverr, exp_err, $sformatf("pslverr on read of offset %0h", addr));
        data = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // header through the union, payload from the seeded generator
    task automatic send_packet(input int idx);
        pkt_word_u         hw;
        logic [data_w-1:0] word;
        int                w;
        hw.hdr.prio = tbl[idx].prio;
        hw.hdr.len  = tbl[idx].len;
        hw.hdr.tag  = tbl[idx].tag;
        for (w = 0; w < tbl[idx].len; w++) begin
            word = (w == 0) ? hw.raw : $random(seed);
            pkt_mem[idx][w] = word;
            @(posedge clk);
            in_vld  <= 1'b1;
            in_sop  <= (w == 0);
            in_eop  <= (w == tbl[idx].len - 1);
            in_data <= word;
        end
        @(posedge clk);
        in_vld <= 1'b0;
        in_sop <= 1'b0;
        in_eop <= 1'b0;
    endtask

    // scoreboard for one batch, then release egress and compare
    task automatic drain_batch(input int first, input int last);
        int                order [$];
        logic [data_w+1:0] exp_q [$];
        int                lead;
        int                i;
        int                p;
        int                w;
        int                cycles;
        int                rnd_val;
        lead = -1;
        if (!tbl[first].stall) begin
            for (i = first; i <= last; i++) begin
                if (tbl[i].keep) begin
                    order.push_back(i);
                end
            end
        end else begin
            // first kept packet is granted while egress is still stalled
            for (i = first; i <= last; i++) begin
                if (tbl[i].keep && lead < 0) begin
                    lead = i;
                end
            end
            if (lead >= 0) begin
                order.push_back(lead);
            end
            // the rest by descending priority, arrival order inside one
            for (p = 7; p >= 0; p--) begin
                for (i = first; i <= last; i++) begin
                    if (tbl[i].keep && tbl[i].prio == p && i != lead) begin
                        order.push_back(i);
                    end
                end
            end
        end
        foreach (order[k]) begin
            for (w = 0; w < tbl[order[k]].len; w++) begin
                exp_q.push_back({w == 0, w == tbl[order[k]].len - 1, pkt_mem[order[k]][w]});
            end
        end
        cycles = 0;
        while (rx_q.size() < exp_q.size()) begin
            if (cycles == wait_limit) begin
                $display("timeout: egress gave %0d of %0d words for the batch ending at row %0d",
                         rx_q.size(), exp_q.size(), last);
                stop_run();
            end else begin
                @(posedge clk);
                rnd_val = $random(seed);
                out_ready <= tbl[last].rnd ? rnd_val[0] : 1'b1;
                cycles++;
            end
        end
        out_ready <= 1'b1;
        // quiet time so a stray or late word would show up
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value(rx_q.size(), exp_q.size(), $sformatf("word count, batch to row %0d", last));
        foreach (exp_q[k]) begin
            check_value(rx_q[k], exp_q[k], $sformatf("egress word %0d, batch to row %0d", k, last));
        end
        rx_q.delete();
    endtask

    // egress monitor, also checks the word is held under back-pressure
    always @(posedge clk) begin
        if (rst) begin
            hold_pend = 1'b0;
        end else begin
            if (hold_pend) begin
                check_value(out_vld, 1'b1, "out_vld dropped while stalled");
                check_value({out_sop, out_eop, out_data}, held_word, "word changed while stalled");
            end
            if (out_vld && out_ready) begin
                rx_q.push_back({out_sop, out_eop, out_data});
            end
            hold_pend = out_vld && !out_ready;
            held_word = {out_sop, out_eop, out_data};
        end
    end

    initial begin
        int                i;
        int                k;
        int                first;
        logic [data_w-1:0] rd;
        logic [3:0]        status_exp;
        seed      = 78056;
        rst       = 1'b1;
        in_sop    = 1'b0;
        in_eop    = 1'b0;
        in_vld    = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        fwd_exp   = 0;
        drop_exp  = 0;
        cur_mask  = 4'hf;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // state right after reset
        check_value(out_vld, 1'b0, "out_vld after reset");
        apb_read(reg_ctrl, 1'b0, rd);
        check_value(rd, 32'hf, "ctrl after reset");
        apb_read(reg_drop_cnt, 1'b0, rd);
        check_value(rd, 0, "drop_cnt after reset");
        apb_read(reg_fwd_cnt, 1'b0, rd);
        check_value(rd, 0, "fwd_cnt after reset");
        first = 0;
        for (i = 0; i < n_entries; i++) begin
            if (i == first) begin
                out_ready <= !tbl[i].stall;
            end
            if (tbl[i].mask != cur_mask) begin
                apb_write(reg_ctrl, data_w'(tbl[i].mask));
                apb_read(reg_ctrl, 1'b0, rd);
                check_value(rd, tbl[i].mask, "ctrl readback");
                cur_mask = tbl[i].mask;
            end
            send_packet(i);
            if (tbl[i].keep) begin
                fwd_exp++;
            end else begin
                drop_exp++;
            end
            if (tbl[i].last) begin
                // non-empty queues while egress is held
                if (tbl[i].stall) begin
                    status_exp = '0;
                    for (k = first; k <= i; k++) begin
                        if (tbl[k].keep) begin
                            status_exp[tbl[k].prio[1:0]] = 1'b1;
                        end
                    end
                    apb_read(reg_status, 1'b0, rd);
                    check_value(rd, status_exp, $sformatf("status at row %0d", i));
                end
                drain_batch(first, i);
                apb_read(reg_drop_cnt, 1'b0, rd);
                check_value(rd, drop_exp, $sformatf("drop_cnt after row %0d", i));
                apb_read(reg_fwd_cnt, 1'b0, rd);
                check_value(rd, fwd_exp, $sformatf("fwd_cnt after row %0d", i));
                first = i + 1;
            end
        end
        // a write clears each counter
        apb_write(reg_drop_cnt, '0);
        apb_read(reg_drop_cnt, 1'b0, rd);
        check_value(rd, 0, "drop_cnt after clear");
        apb_write(reg_fwd_cnt, '0);
        apb_read(reg_fwd_cnt, 1'b0, rd);
        check_value(rd, 0, "fwd_cnt after clear");
        // offset between mapped registers
        apb_read(4'h2, 1'b1, rd);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
source/pq_pkg.sv
source/pkt_word_if.sv
source/pkt_fifo.sv
source/pkt_classifier.sv
source/strict_sched.sv
source/pq_regs.sv
source/pq_top.sv
tests/pq_clk_gen.sv
tests/pq_tb.sv

//--- Bender.yml
package:
  name: pq

sources:
  - files:
      - source/pq_pkg.sv
      - source/pkt_word_if.sv
      - source/pkt_fifo.sv
      - source/pkt_classifier.sv
      - source/strict_sched.sv
      - source/pq_regs.sv
      - source/pq_top.sv
  - target: test
    files:
      - tests/pq_clk_gen.sv
      - tests/pq_tb.sv
